//--- hdl/axi_lite_to_mem.sv
/*
 * Single-beat AXI-style slave to memory request converter
 * Handles one transaction at a time with reads taking priority.
 * The accepted request is range checked against N_BYTES, issued as
 * one word request, and its response is queued in a stream register.
 */

`default_nettype none

module axi_lite_to_mem import l2_mem_pkg::*; #(
  parameter int unsigned N_BYTES = 4096
) (
  input  wire logic     clk_i,
  input  wire logic     rst_ni,
  // Write address
  input  wire logic     aw_valid_i,
  output logic          aw_ready_o,
  input  wire aw_chan_t aw_i,
  // Write data
  input  wire logic     w_valid_i,
  output logic          w_ready_o,
  input  wire w_chan_t  w_i,
  // Write response
  output logic          b_valid_o,
  input  wire logic     b_ready_i,
  output b_chan_t       b_o,
  // Read address
  input  wire logic     ar_valid_i,
  output logic          ar_ready_o,
  input  wire ar_chan_t ar_i,
  // Read data
  output logic          r_valid_o,
  input  wire logic     r_ready_i,
  output r_chan_t       r_o,
  // Memory side
  output logic          mem_req_valid_o,
  output mem_req_t      mem_req_o,
  input  wire data_t    mem_rdata_i
);

  typedef enum logic [2:0] {
    StInit,
    StIdle,
    StCheck,
    StMem,
    StResp
  } state_e;

  state_e  state_q, state_d;
  logic    is_read_q, in_range_q;
  addr_t   addr_q;
  data_t   wdata_q;
  strb_t   strb_q;
  logic    rsp_free, accept_ar, accept_wr, wr_ready;
  logic    b_push, b_push_ready, r_push, r_push_ready;
  resp_t   rsp_code;
  b_chan_t b_push_data;
  r_chan_t r_push_data;

  // Both response slots must be free or draining before a new accept
  assign rsp_free   = b_push_ready && r_push_ready;
  assign ar_ready_o = (state_q == StIdle) && rsp_free;
  // AW and W only go together, and only when no read is offered
  assign wr_ready   = (state_q == StIdle) && rsp_free && !ar_valid_i &&
                      aw_valid_i && w_valid_i;
  assign aw_ready_o = wr_ready;
  assign w_ready_o  = wr_ready;

  assign accept_ar = ar_valid_i && ar_ready_o;
  assign accept_wr = aw_valid_i && wr_ready;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      StInit:  state_d = StIdle;
      StIdle:  if (accept_ar || accept_wr) state_d = StCheck;
      StCheck: state_d = StMem;
      StMem:   state_d = StResp;
      StResp: begin
        if (is_read_q ? r_push_ready : b_push_ready) begin
          state_d = StIdle;
        end
      end
      default: state_d = StInit;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= StInit;
      is_read_q  <= 1'b0;
      in_range_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (accept_ar || accept_wr) begin
        is_read_q <= accept_ar;
      end
      // Registered compare keeps the range check off the issue path
      if (state_q == StCheck) begin
        in_range_q <= addr_q < addr_t'(N_BYTES);
      end
    end
  end

  // Request payload
  always_ff @(posedge clk_i) begin
    if (accept_ar) begin
      addr_q <= ar_i.addr;
    end else if (accept_wr) begin
      addr_q  <= aw_i.addr;
      wdata_q <= w_i.data;
      strb_q  <= w_i.strb;
    end
  end

  // Out-of-range requests never reach the array
  assign mem_req_valid_o = (state_q == StMem) && in_range_q;
  assign mem_req_o.addr  = addr_q;
  assign mem_req_o.we    = !is_read_q;
  assign mem_req_o.wdata = wdata_q;
  assign mem_req_o.strb  = strb_q;

  // Read data arrives from the array while in StResp
  assign rsp_code         = in_range_q ? RespOkay : RespSlvErr;
  assign r_push           = (state_q == StResp) && is_read_q;
  assign b_push           = (state_q == StResp) && !is_read_q;
  assign r_push_data.data = in_range_q ? mem_rdata_i : '0;
  assign r_push_data.resp = rsp_code;
  assign b_push_data.resp = rsp_code;

  stream_reg #(
    .payload_t (b_chan_t)
  ) i_b_reg (
    .clk_i,
    .rst_ni,
    .valid_i (b_push),
    .ready_o (b_push_ready),
    .data_i  (b_push_data),
    .valid_o (b_valid_o),
    .ready_i (b_ready_i),
    .data_o  (b_o)
  );

  stream_reg #(
    .payload_t (r_chan_t)
  ) i_r_reg (
    .clk_i,
    .rst_ni,
    .valid_i (r_push),
    .ready_o (r_push_ready),
    .data_i  (r_push_data),
    .valid_o (r_valid_o),
    .ready_i (r_ready_i),
    .data_o  (r_o)
  );

endmodule

`default_nettype wire

//--- hdl/l2_mem.sv
/*
 * L2 scratchpad memory
 * Single-beat AXI-style slave port in front of a tiled SRAM array.
 */

`default_nettype none

module l2_mem import l2_mem_pkg::*; #(
  parameter int unsigned N_BYTES = 4096
) (
  input  wire logic     clk_i,
  input  wire logic     rst_ni,
  input  wire logic     aw_valid_i,
  output logic          aw_ready_o,
  input  wire aw_chan_t aw_i,
  input  wire logic     w_valid_i,
  output logic          w_ready_o,
  input  wire w_chan_t  w_i,
  output logic          b_valid_o,
  input  wire logic     b_ready_i,
  output b_chan_t       b_o,
  input  wire logic     ar_valid_i,
  output logic          ar_ready_o,
  input  wire ar_chan_t ar_i,
  output logic          r_valid_o,
  input  wire logic     r_ready_i,
  output r_chan_t       r_o
);

  logic     mem_req_valid;
  mem_req_t mem_req;
  data_t    mem_rdata;

  axi_lite_to_mem #(
    .N_BYTES (N_BYTES)
  ) i_axi_to_mem (
    .clk_i,
    .rst_ni,
    .aw_valid_i,
    .aw_ready_o,
    .aw_i,
    .w_valid_i,
    .w_ready_o,
    .w_i,
    .b_valid_o,
    .b_ready_i,
    .b_o,
    .ar_valid_i,
    .ar_ready_o,
    .ar_i,
    .r_valid_o,
    .r_ready_i,
    .r_o,
    .mem_req_valid_o (mem_req_valid),
    .mem_req_o       (mem_req),
    .mem_rdata_i     (mem_rdata)
  );

  mem_cut_array #(
    .N_BYTES (N_BYTES)
  ) i_cut_array (
    .clk_i,
    .rst_ni,
    .req_valid_i (mem_req_valid),
    .req_i       (mem_req),
    .rdata_o     (mem_rdata)
  );

endmodule

`default_nettype wire

//--- hdl/l2_mem_pkg.sv
/*
 * L2 scratchpad shared definitions
 * Bus widths, SRAM cut geometry, response codes and the channel
 * structs of the single-beat AXI-style slave port.
 */

`default_nettype none

package l2_mem_pkg;

  // Bus geometry
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 64;
  localparam int unsigned StrbWidth = DataWidth / 8;

  // One SRAM macro, keep in line with the cut that gets instantiated
  localparam int unsigned CutDataWidth = 32;
  localparam int unsigned CutNumWords  = 256;
  localparam int unsigned NumParCuts   = DataWidth / CutDataWidth;

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [StrbWidth-1:0] strb_t;
  typedef logic [1:0]           resp_t;

  localparam resp_t RespOkay   = 2'b00;
  localparam resp_t RespSlvErr = 2'b10;

  typedef struct packed {
    addr_t addr;
  } aw_chan_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
  } w_chan_t;

  typedef struct packed {
    resp_t resp;
  } b_chan_t;

  typedef struct packed {
    addr_t addr;
  } ar_chan_t;

  typedef struct packed {
    data_t data;
    resp_t resp;
  } r_chan_t;

  // Word request from the protocol converter to the cut array
  typedef struct packed {
    addr_t addr;
    logic  we;
    data_t wdata;
    strb_t strb;
  } mem_req_t;

endpackage

`default_nettype wire

//--- hdl/mem_cut_array.sv
/*
 * SRAM cut array
 * Cuts side by side cover the bus width, stacked rows cover the
 * capacity. Only the addressed row is enabled, and a registered row
 * index selects the read data one cycle after the request.
 */

`default_nettype none

module mem_cut_array import l2_mem_pkg::*; #(
  parameter int unsigned N_BYTES = 4096
) (
  input  wire logic     clk_i,
  input  wire logic     rst_ni,
  input  wire logic     req_valid_i,
  input  wire mem_req_t req_i,
  output data_t         rdata_o
);

  // Bytes covered by one row of cuts
  localparam int unsigned RowBytes = NumParCuts * CutNumWords * CutDataWidth / 8;
  localparam int unsigned NumRows  = N_BYTES / RowBytes;

  // Byte address layout: row | word | byte in bus word
  localparam int unsigned WordOff  = $clog2(StrbWidth);
  localparam int unsigned WordIdxW = $clog2(CutNumWords);
  localparam int unsigned RowOff   = WordOff + WordIdxW;
  localparam int unsigned RowIdxW  = $clog2(NumRows);

  logic [NumRows-1:0]                                  cut_req;
  logic [WordIdxW-1:0]                                 word_addr_d, word_addr_q;
  logic [NumRows-1:0][NumParCuts-1:0][CutDataWidth-1:0] cut_rdata;
  logic [NumParCuts-1:0][CutDataWidth-1:0]             cut_wdata;
  logic [NumParCuts-1:0][CutDataWidth/8-1:0]           cut_be;

  // Hold the last word address between requests
  assign word_addr_d = req_valid_i ? req_i.addr[RowOff-1:WordOff] : word_addr_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      word_addr_q <= '0;
    end else begin
      word_addr_q <= word_addr_d;
    end
  end

  if (RowIdxW > 0) begin : gen_row_idx
    logic [RowIdxW-1:0] row_idx_d, row_idx_q;

    assign row_idx_d = req_valid_i ? req_i.addr[RowOff +: RowIdxW] : row_idx_q;

    always_comb begin
      cut_req            = '0;
      cut_req[row_idx_d] = req_valid_i;
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        row_idx_q <= '0;
      end else begin
        row_idx_q <= row_idx_d;
      end
    end

    // Row of the previous request
    assign rdata_o = cut_rdata[row_idx_q];
  end else begin : gen_no_row_idx
    assign cut_req = req_valid_i;
    assign rdata_o = cut_rdata[0];
  end

  // Slice the bus word across the columns
  assign cut_wdata = req_i.wdata;
  assign cut_be    = req_i.strb;

  for (genvar row = 0; row < NumRows; row++) begin : gen_rows
    for (genvar col = 0; col < NumParCuts; col++) begin : gen_cols
      sram #(
        .DATA_W  (CutDataWidth),
        .N_WORDS (CutNumWords)
      ) i_cut (
        .clk_i,
        .req_i   (cut_req[row]),
        .we_i    (req_i.we),
        .addr_i  (word_addr_d),
        .wdata_i (cut_wdata[col]),
        .be_i    (cut_be[col]),
        .rdata_o (cut_rdata[row][col])
      );
    end
  end

endmodule

`default_nettype wire

//--- hdl/sram.sv
/*
 * Behavioral single-port SRAM cut
 * Byte-enabled writes, read data registered one cycle after the
 * request. A write request returns the freshly written word.
 */

`default_nettype none

module sram #(
  parameter int unsigned DATA_W  = 32,
  parameter int unsigned N_WORDS = 256
) (
  input  wire logic                       clk_i,
  input  wire logic                       req_i,
  input  wire logic                       we_i,
  input  wire logic [$clog2(N_WORDS)-1:0] addr_i,
  input  wire logic [DATA_W-1:0]          wdata_i,
  input  wire logic [DATA_W/8-1:0]        be_i,
  output logic      [DATA_W-1:0]          rdata_o
);

  logic [DATA_W-1:0] mem_q [N_WORDS];
  logic [DATA_W-1:0] rdata_q;
  logic [DATA_W-1:0] wr_word;

  // Merge enabled bytes into the stored word
  always_comb begin
    wr_word = mem_q[addr_i];
    for (int i = 0; i < DATA_W / 8; i++) begin
      if (be_i[i]) begin
        wr_word[8*i +: 8] = wdata_i[8*i +: 8];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        mem_q[addr_i] <= wr_word;
        rdata_q       <= wr_word;
      end else begin
        rdata_q <= mem_q[addr_i];
      end
    end
  end

  assign rdata_o = rdata_q;

endmodule

`default_nettype wire

//--- hdl/stream_reg.sv
/*
 * One-entry valid/ready register
 * Holds a single payload of any type from the load edge until the
 * output transfer. Accepts a new entry while draining the old one.
 */

`default_nettype none

module stream_reg #(
  parameter type payload_t = logic
) (
  input  wire logic     clk_i,
  input  wire logic     rst_ni,
  // Input side
  input  wire logic     valid_i,
  output logic          ready_o,
  input  wire payload_t data_i,
  // Output side
  output logic          valid_o,
  input  wire logic     ready_i,
  output payload_t      data_o
);

  logic     full_q;
  payload_t data_q;

  // Empty, or the current entry leaves on this edge
  assign ready_o = !full_q || ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      full_q <= 1'b0;
    end else if (ready_o) begin
      full_q <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i && ready_o) begin
      data_q <= data_i;
    end
  end

  assign valid_o = full_q;
  assign data_o  = data_q;

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the L2 scratchpad testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=build
LOG=sim.log

mkdir -p "$BUILD_DIR"
if [ $? -ne 0 ]; then
  echo "cannot create $BUILD_DIR"
  exit 1
fi

verilator --binary --timing --assert -Wno-fatal -f sim.f \
  --top-module tb_l2_mem -Mdir "$BUILD_DIR"
if [ $? -ne 0 ]; then
  echo "compilation failed"
  exit 1
fi

"./$BUILD_DIR/Vtb_l2_mem" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
  exit 1
fi
exit 0

//--- sim.f
hdl/l2_mem_pkg.sv
hdl/sram.sv
hdl/stream_reg.sv
hdl/axi_lite_to_mem.sv
hdl/mem_cut_array.sv
hdl/l2_mem.sv
test/l2_mem_checker.sv
test/l2_mem_asserts.sv
test/tb_l2_mem.sv

//--- test/l2_mem_asserts.sv
/*
 * Handshake and memory request assertions for the AXI-style converter
 */

`default_nettype none

module l2_mem_asserts import l2_mem_pkg::*; #(
  parameter int unsigned N_BYTES = 4096
) (
  input wire logic     clk_i,
  input wire logic     rst_ni,
  input wire logic     ar_valid_i,
  input wire logic     ar_ready_o,
  input wire logic     aw_valid_i,
  input wire logic     aw_ready_o,
  input wire logic     b_valid_o,
  input wire logic     b_ready_i,
  input wire b_chan_t  b_o,
  input wire logic     r_valid_o,
  input wire logic     r_ready_i,
  input wire r_chan_t  r_o,
  input wire logic     mem_req_valid_o,
  input wire mem_req_t mem_req_o
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned RowBytes = NumParCuts * CutNumWords * CutDataWidth / 8;

  // Capacity must be a whole number of cut rows
  a_geometry: assert property (@(posedge clk_i) (N_BYTES % RowBytes == 0) && (N_BYTES >= RowBytes))
    else $error("N_BYTES is not a multiple of the row size");

  a_b_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    b_valid_o && !b_ready_i |=> b_valid_o && $stable(b_o))
    else $error("B valid or payload changed before transfer");

  a_r_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    r_valid_o && !r_ready_i |=> r_valid_o && $stable(r_o))
    else $error("R valid or payload changed before transfer");

  a_ar_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ar_valid_i && !ar_ready_o |=> ar_valid_i)
    else $error("AR valid dropped before transfer");

  a_aw_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    aw_valid_i && !aw_ready_o |=> aw_valid_i)
    else $error("AW valid dropped before transfer");

  a_req_range: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_valid_o |-> mem_req_o.addr < N_BYTES)
    else $error("memory request issued for an out-of-range address");

  a_one_rsp: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(b_valid_o && r_valid_o))
    else $error("both response registers full");

endmodule

bind axi_lite_to_mem l2_mem_asserts #(
  .N_BYTES (N_BYTES)
) i_asserts (
  .clk_i           (clk_i),
  .rst_ni          (rst_ni),
  .ar_valid_i      (ar_valid_i),
  .ar_ready_o      (ar_ready_o),
  .aw_valid_i      (aw_valid_i),
  .aw_ready_o      (aw_ready_o),
  .b_valid_o       (b_valid_o),
  .b_ready_i       (b_ready_i),
  .b_o             (b_o),
  .r_valid_o       (r_valid_o),
  .r_ready_i       (r_ready_i),
  .r_o             (r_o),
  .mem_req_valid_o (mem_req_valid_o),
  .mem_req_o       (mem_req_o)
);

`default_nettype wire

//--- test/l2_mem_checker.sv
/*
 * L2 scratchpad response checker
 * Watches the DUT ports, keeps a byte-array model of the memory,
 * predicts every R and B response and counts mismatches.
 */

`default_nettype none

module l2_mem_checker import l2_mem_pkg::*; #(
  parameter int unsigned N_BYTES = 4096
) (
  input  wire logic       clk_i,
  input  wire logic       rst_ni,
  input  wire logic       aw_valid_i,
  input  wire logic       aw_ready_i,
  input  wire aw_chan_t   aw_i,
  input  wire logic       w_valid_i,
  input  wire logic       w_ready_i,
  input  wire w_chan_t    w_i,
  input  wire logic       b_valid_i,
  input  wire logic       b_ready_i,
  input  wire b_chan_t    b_i,
  input  wire logic       ar_valid_i,
  input  wire logic       ar_ready_i,
  input  wire ar_chan_t   ar_i,
  input  wire logic       r_valid_i,
  input  wire logic       r_ready_i,
  input  wire r_chan_t    r_i,
  input  wire logic       test_done_i,
  input  wire logic [2:0] test_idx_i,
  output int unsigned     err_cnt_o
);

  timeunit 1ns;
  timeprecision 1ps;

  logic [7:0]  model [N_BYTES];
  r_chan_t     r_exp_q [$];
  resp_t       b_exp_q [$];
  int unsigned errors = 0;
  int unsigned checks = 0;
  int unsigned err_start = 0;
  int unsigned chk_start = 0;
  int          cyc = 0;
  int          ar_cyc = 0;
  int          aw_cyc = 0;
  logic        r_valid_q = 1'b0;
  logic        b_valid_q = 1'b0;
  logic        rst_seen = 1'b0;

  assign err_cnt_o = errors;

  function automatic string test_name(input logic [2:0] idx);
    case (idx)
      3'd0:    return "reset";
      3'd1:    return "fill";
      3'd2:    return "write_read";
      3'd3:    return "byte_strobe";
      3'd4:    return "out_of_range";
      3'd5:    return "random";
      default: return "unknown";
    endcase
  endfunction

  function automatic void value_error(input string what, input logic [63:0] exp_val,
                                      input logic [63:0] act_val);
    errors++;
    $display("error %s: %s expected %h actual %h", test_name(test_idx_i), what,
             exp_val, act_val);
  endfunction

  function automatic void other_error(input string what);
    errors++;
    $display("%s: %s", test_name(test_idx_i), what);
  endfunction

  // Reads see the word that holds the byte address
  function automatic r_chan_t predict_read(input addr_t addr);
    r_chan_t rsp;
    addr_t   base;
    base     = addr & ~addr_t'(StrbWidth - 1);
    rsp.data = '0;
    rsp.resp = RespSlvErr;
    if (addr < N_BYTES) begin
      rsp.resp = RespOkay;
      for (int i = 0; i < StrbWidth; i++) begin
        rsp.data[8*i +: 8] = model[base + i];
      end
    end
    return rsp;
  endfunction

  function automatic resp_t apply_write(input addr_t addr, input w_chan_t w);
    addr_t base;
    base = addr & ~addr_t'(StrbWidth - 1);
    if (addr >= N_BYTES) begin
      return RespSlvErr;
    end
    for (int i = 0; i < StrbWidth; i++) begin
      if (w.strb[i]) begin
        model[base + i] = w.data[8*i +: 8];
      end
    end
    return RespOkay;
  endfunction

  function automatic bit outputs_idle();
    return !(aw_ready_i || w_ready_i || ar_ready_i || b_valid_i || r_valid_i);
  endfunction

  always @(posedge clk_i) begin
    r_chan_t r_exp;
    resp_t   b_exp;
    cyc++;
    if (!rst_ni) begin
      checks++;
      if (!outputs_idle()) other_error("ready or valid output high during reset");
    end else begin
      if (!rst_seen) begin
        rst_seen = 1'b1;
        checks++;
        if (!outputs_idle()) other_error("ready or valid output high after reset");
      end
      // Response latency is fixed by the converter FSM
      // Valid rises on an edge and is first sampled on the edge after it
      if (r_valid_i && !r_valid_q && (cyc - ar_cyc - 1 != 3)) begin
        value_error("R latency", 64'(3), 64'(cyc - ar_cyc - 1));
      end
      if (b_valid_i && !b_valid_q && (cyc - aw_cyc - 1 != 3)) begin
        value_error("B latency", 64'(3), 64'(cyc - aw_cyc - 1));
      end
      if (r_valid_i && r_ready_i) begin
        checks++;
        if (r_exp_q.size() == 0) begin
          other_error("R response without a pending read");
        end else begin
          r_exp = r_exp_q.pop_front();
          if (r_i.data !== r_exp.data) value_error("R data", r_exp.data, r_i.data);
          if (r_i.resp !== r_exp.resp) value_error("R resp", 64'(r_exp.resp), 64'(r_i.resp));
        end
      end
      if (b_valid_i && b_ready_i) begin
        checks++;
        if (b_exp_q.size() == 0) begin
          other_error("B response without a pending write");
        end else begin
          b_exp = b_exp_q.pop_front();
          if (b_i.resp !== b_exp) value_error("B resp", 64'(b_exp), 64'(b_i.resp));
        end
      end
      if (ar_valid_i && ar_ready_i) begin
        r_exp_q.push_back(predict_read(ar_i.addr));
        ar_cyc = cyc;
      end
      if (aw_valid_i && aw_ready_i) begin
        if (!(w_valid_i && w_ready_i)) other_error("AW accepted without its W beat");
        // Reads have priority over writes
        if (ar_valid_i) other_error("write accepted while a read was offered");
        if (r_exp_q.size() != 0) other_error("write accepted before the read completed");
        b_exp_q.push_back(apply_write(aw_i.addr, w_i));
        aw_cyc = cyc;
      end
      r_valid_q = r_valid_i;
      b_valid_q = b_valid_i;
    end
    if (test_done_i) begin
      if (r_exp_q.size() != 0 || b_exp_q.size() != 0) begin
        other_error("responses still outstanding at end of test");
      end
      $display("test %-12s done: %0d checks, %0d errors", test_name(test_idx_i),
               checks - chk_start, errors - err_start);
      chk_start = checks;
      err_start = errors;
    end
  end

endmodule

`default_nettype wire

//--- test/tb_l2_mem.sv
/*
 * L2 scratchpad testbench
 * Clock, reset and random single-beat traffic against the DUT.
 * Responses are compared by the checker instance.
 */

`default_nettype none

module tb_l2_mem;

  import l2_mem_pkg::*;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned NBytes  = 4096;
  localparam int          Timeout = 100;

  logic        clk_i;
  logic        rst_ni;
  logic        aw_valid, aw_ready, w_valid, w_ready, b_valid, b_ready;
  logic        ar_valid, ar_ready, r_valid, r_ready;
  aw_chan_t    aw;
  w_chan_t     w;
  b_chan_t     b;
  ar_chan_t    ar;
  r_chan_t     r;
  logic        test_done;
  logic [2:0]  test_idx;
  logic        rand_ready;
  int unsigned err_cnt;
  int unsigned timeouts = 0;

  l2_mem #(
    .N_BYTES (NBytes)
  ) l2_mem_i (
    .clk_i, .rst_ni,
    .aw_valid_i (aw_valid), .aw_ready_o (aw_ready), .aw_i (aw),
    .w_valid_i  (w_valid),  .w_ready_o  (w_ready),  .w_i  (w),
    .b_valid_o  (b_valid),  .b_ready_i  (b_ready),  .b_o  (b),
    .ar_valid_i (ar_valid), .ar_ready_o (ar_ready), .ar_i (ar),
    .r_valid_o  (r_valid),  .r_ready_i  (r_ready),  .r_o  (r)
  );

  l2_mem_checker #(
    .N_BYTES (NBytes)
  ) i_checker (
    .clk_i, .rst_ni,
    .aw_valid_i (aw_valid), .aw_ready_i (aw_ready), .aw_i (aw),
    .w_valid_i  (w_valid),  .w_ready_i  (w_ready),  .w_i  (w),
    .b_valid_i  (b_valid),  .b_ready_i  (b_ready),  .b_i  (b),
    .ar_valid_i (ar_valid), .ar_ready_i (ar_ready), .ar_i (ar),
    .r_valid_i  (r_valid),  .r_ready_i  (r_ready),  .r_i  (r),
    .test_done_i (test_done),
    .test_idx_i  (test_idx),
    .err_cnt_o   (err_cnt)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // Response ready, random under back-pressure
  initial begin
    forever begin
      @(posedge clk_i);
      #1;
      r_ready = rand_ready ? 1'($urandom % 2) : 1'b1;
      b_ready = rand_ready ? 1'($urandom % 2) : 1'b1;
    end
  end

  function automatic data_t fill_word(input addr_t a);
    return {a ^ 32'hc3a5_9e17, a[15:0], ~a[15:0]};
  endfunction

  function automatic addr_t rand_addr(input int unsigned limit);
    return addr_t'(($urandom % (limit / StrbWidth)) * StrbWidth);
  endfunction

  task automatic note_timeout(input string what);
    timeouts++;
    $display("timeout: no %s within %0d cycles", what, Timeout);
  endtask

  // Tasks start and end just after a rising edge
  task automatic read_txn(input addr_t addr);
    bit hs;
    hs = 1'b0;
    #1;
    ar_valid = 1'b1;
    ar.addr  = addr;
    for (int t = 0; t < Timeout && !hs; t++) begin
      @(posedge clk_i);
      hs = ar_ready;
    end
    #1;
    ar_valid = 1'b0;
    if (!hs) begin
      note_timeout("AR ready");
    end else begin
      hs = 1'b0;
      for (int t = 0; t < Timeout && !hs; t++) begin
        @(posedge clk_i);
        hs = r_valid && r_ready;
      end
      if (!hs) note_timeout("R response");
    end
  endtask

  task automatic write_txn(input addr_t addr, input data_t data, input strb_t strb);
    bit hs;
    hs = 1'b0;
    #1;
    aw_valid = 1'b1;
    aw.addr  = addr;
    w_valid  = 1'b1;
    w.data   = data;
    w.strb   = strb;
    for (int t = 0; t < Timeout && !hs; t++) begin
      @(posedge clk_i);
      hs = aw_ready && w_ready;
    end
    #1;
    aw_valid = 1'b0;
    w_valid  = 1'b0;
    if (!hs) begin
      note_timeout("AW/W ready");
    end else begin
      hs = 1'b0;
      for (int t = 0; t < Timeout && !hs; t++) begin
        @(posedge clk_i);
        hs = b_valid && b_ready;
      end
      if (!hs) note_timeout("B response");
    end
  endtask

  // Done flag is held across one rising edge so the checker samples it
  task automatic finish_test(input logic [2:0] idx);
    #1;
    test_idx  = idx;
    test_done = 1'b1;
    @(posedge clk_i);
    #1;
    test_done = 1'b0;
    @(posedge clk_i);
  endtask

  initial begin
    addr_t a;
    data_t d;
    strb_t s;
    int    kind;
    void'($urandom(32'h3e67));
    rst_ni     = 1'b0;
    aw_valid   = 1'b0;
    w_valid    = 1'b0;
    ar_valid   = 1'b0;
    b_ready    = 1'b1;
    r_ready    = 1'b1;
    aw         = '0;
    w          = '0;
    ar         = '0;
    test_done  = 1'b0;
    test_idx   = '0;
    rand_ready = 1'b0;
    repeat (16) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    @(posedge clk_i);

    // Out-of-range first read, its response does not depend on memory contents
    read_txn(addr_t'(NBytes));
    finish_test(3'd0);

    for (int unsigned i = 0; i < NBytes; i += StrbWidth) begin
      write_txn(addr_t'(i), fill_word(addr_t'(i)), '1);
    end
    finish_test(3'd1);

    // Alternate rows so both are exercised
    for (int i = 0; i < 24; i++) begin
      a = addr_t'((i % 2) * (NBytes / 2)) + rand_addr(NBytes / 2);
      write_txn(a, {$urandom, $urandom}, '1);
      read_txn(a);
    end
    finish_test(3'd2);

    for (int i = 0; i < 24; i++) begin
      a = rand_addr(NBytes);
      s = strb_t'($urandom);
      if (s == '0 || s == '1) s = 8'h5a;
      write_txn(a, {$urandom, $urandom}, s);
      read_txn(a);
    end
    finish_test(3'd3);

    for (int i = 0; i < 8; i++) begin
      a = addr_t'(NBytes) + rand_addr(NBytes);
      write_txn(a, {$urandom, $urandom}, '1);
      read_txn(a);
      // Aliased in-range word must be untouched
      read_txn(a - addr_t'(NBytes));
    end
    finish_test(3'd4);

    rand_ready = 1'b1;
    for (int i = 0; i < 80; i++) begin
      kind = $urandom % 3;
      a    = rand_addr((i % 8 == 7) ? 2 * NBytes : NBytes);
      d    = {$urandom, $urandom};
      s    = strb_t'($urandom);
      case (kind)
        0: read_txn(a);
        1: write_txn(a, d, s);
        default: begin
          fork
            read_txn(a);
            write_txn(rand_addr(NBytes), d, s);
          join
        end
      endcase
    end
    rand_ready = 1'b0;
    finish_test(3'd5);

    $display("tests done: %0d errors, %0d timeouts", err_cnt, timeouts);
    if (err_cnt == 0 && timeouts == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
